/* design/orbitron_pkg.sv */
//==================================================
// Orbitron board glue shared definitions
// Bus widths, option-byte bit positions and the
// scanline effect encoding used across the glue
//==================================================
package orbitron_pkg;

	// Option byte as shifted in from the host, one bit per menu entry
	typedef logic [7:0] opt_byte_t;

	// ==================================================
	// Option-bit positions
	// ==================================================

	// Either of the two reset bits restarts the core
	localparam int OPT_RESET   = 0;
	localparam int OPT_RESET_T = 6;

	// Set selects the upright joystick mapping
	localparam int OPT_ROTATE = 2;

	// Low bit of the two-bit scanline effect field
	localparam int OPT_FX_LO = 3;

	// Scanline effect, in the order the host menu lists it
	typedef enum logic [1:0] {
		FX_NONE  = 2'd0,
		FX_HQ2X  = 2'd1,
		FX_CRT25 = 2'd2,
		FX_CRT50 = 2'd3
	} fx_mode_t;

	// ==================================================
	// Datapath widths
	// ==================================================

	// Keyboard joystick word from the PS/2 decoder
	localparam int KBJOY_W = 10;
	localparam int JOY_W   = 8;

	// Sound channels and their weighted sum
	localparam int SND_W = 8;
	localparam int MIX_W = 11;

	// Output colour depth per channel
	localparam int VGA_W = 6;

endpackage

/* design/cfg_if.sv */
//==================================================
// Configuration bus
// Decoded option levels and the update strobe, from
// the option receiver to the control and video logic
//==================================================
`timescale 1ns/1ps

interface cfg_if;
	import orbitron_pkg::*;

	logic     rotate;
	fx_mode_t fx_mode;
	logic     reset_req;
	// High for one clock when a newly received byte takes effect
	logic     cfg_update;

	modport source (
		output rotate,
		output fx_mode,
		output reset_req,
		output cfg_update
	);

	modport sink (
		input rotate,
		input fx_mode,
		input reset_req,
		input cfg_update
	);

endinterface

/* design/option_rx.sv */
//==================================================
// Option byte receiver
// Captures the 8-bit option byte sent by the host
// over the SS/SCK/DI link and decodes it into the
// configuration levels
//==================================================
`timescale 1ns/1ps

module option_rx (
	input  logic  clk_18,
	input  logic  rst_n,
	input  logic  spi_sck,
	input  logic  spi_ss,
	input  logic  spi_di,
	cfg_if.source cfg
);
	import orbitron_pkg::*;

	localparam int               CNT_W      = 4;
	localparam logic [CNT_W-1:0] FRAME_BITS = 4'd8;
	// Saturation point, anything past a full byte is a bad frame
	localparam logic [CNT_W-1:0] CNT_MAX    = 4'd9;

	// Stage 0 and 1 synchronise, stage 2 holds the previous value for edges
	logic [2:0]       sck_pipe;
	logic [2:0]       ss_pipe;
	logic [1:0]       di_pipe;
	logic             sck_rise;
	logic             ss_rise;
	logic             ss_active;
	opt_byte_t        shift_q;
	opt_byte_t        opt_q;
	logic [CNT_W-1:0] bit_cnt;
	logic             update_q;

	// ==================================================
	// Link synchronisers
	// ==================================================

	always_ff @(posedge clk_18 or negedge rst_n) begin
		if (!rst_n) begin
			sck_pipe <= '0;
			// Slave select idles high
			ss_pipe  <= '1;
			di_pipe  <= '0;
		end else begin
			sck_pipe <= {sck_pipe[1:0], spi_sck};
			ss_pipe  <= {ss_pipe[1:0], spi_ss};
			di_pipe  <= {di_pipe[0], spi_di};
		end
	end

	assign sck_rise  = sck_pipe[1] & ~sck_pipe[2];
	assign ss_rise   = ss_pipe[1] & ~ss_pipe[2];
	assign ss_active = ~ss_pipe[1];

	// ==================================================
	// Shifter, bit counter and commit
	// ==================================================

	// MSB first, so new bits enter at the bottom
	always_ff @(posedge clk_18) begin
		if (ss_active && sck_rise) begin
			shift_q <= {shift_q[6:0], di_pipe[1]};
		end
	end

	always_ff @(posedge clk_18 or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			opt_q    <= '0;
			update_q <= 1'b0;
		end else begin
			if (!ss_active) begin
				bit_cnt <= '0;
			end else if (sck_rise && bit_cnt != CNT_MAX) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			// Only a frame of exactly eight bits replaces the stored byte
			update_q <= ss_rise && (bit_cnt == FRAME_BITS);
			if (ss_rise && bit_cnt == FRAME_BITS) begin
				opt_q <= shift_q;
			end
		end
	end

	assign cfg.rotate     = opt_q[OPT_ROTATE];
	assign cfg.fx_mode    = fx_mode_t'(opt_q[OPT_FX_LO +: 2]);
	assign cfg.reset_req  = opt_q[OPT_RESET] | opt_q[OPT_RESET_T];
	assign cfg.cfg_update = update_q;

endmodule

/* design/player_controls.sv */
//==================================================
// Player controls
// Merges the keyboard and both joysticks into the two
// CSJUDLR control words, with upright/normal rotation
//==================================================
`timescale 1ns/1ps

module player_controls (
	input  logic                              clk_18,
	input  logic                              rst_n,
	input  logic [orbitron_pkg::KBJOY_W-1:0] kbjoy,
	input  logic [orbitron_pkg::JOY_W-1:0]   joystick_0,
	input  logic [orbitron_pkg::JOY_W-1:0]   joystick_1,
	cfg_if.sink                               cfg,
	output logic [7:0]                        p1_csjudlr,
	output logic [7:0]                        p2_csjudlr
);

	// Raw direction sources in the upright orientation
	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;
	logic m_fire;

	assign src_up    = kbjoy[7] | joystick_0[0] | joystick_1[0];
	assign src_down  = kbjoy[6] | joystick_0[1] | joystick_1[1];
	assign src_left  = kbjoy[4] | joystick_0[3] | joystick_1[3];
	assign src_right = kbjoy[5] | joystick_0[2] | joystick_1[2];

	// Normal mode turns the stick a quarter turn for the sideways monitor
	assign m_up    = cfg.rotate ? src_up    : src_left;
	assign m_down  = cfg.rotate ? src_down  : src_right;
	assign m_left  = cfg.rotate ? src_left  : src_down;
	assign m_right = cfg.rotate ? src_right : src_up;

	assign m_fire = kbjoy[0] | joystick_0[4] | joystick_1[4];

	// The CSJUDLR fields sit in bits 6 to 0, bit 7 is spare
	always_ff @(posedge clk_18 or negedge rst_n) begin
		if (!rst_n) begin
			p1_csjudlr <= '0;
			p2_csjudlr <= '0;
		end else begin
			p1_csjudlr <= {1'b0, kbjoy[3], kbjoy[1], m_fire, 2'b00, m_right, m_left};
			p2_csjudlr <= {1'b0, 1'b0, kbjoy[2], m_fire, 2'b00, m_up, m_down};
		end
	end

endmodule

/* design/sound_dac.sv */
//==================================================
// Sound mixer and DAC
// Weights and sums the two sound channels, then turns
// the sum into a one-bit first-order sigma-delta
// stream for the audio pins
//==================================================
`timescale 1ns/1ps

module sound_dac (
	input  logic                            clk_18,
	input  logic                            rst_n,
	input  logic [orbitron_pkg::SND_W-1:0] audio_a,
	input  logic [orbitron_pkg::SND_W-1:0] audio_b,
	output logic                            audio_l
);
	import orbitron_pkg::*;

	logic [MIX_W-1:0] mix;
	logic [MIX_W-1:0] mix_q;
	// One bit wider than the mix, the top bit is the carry out
	logic [MIX_W:0]   acc_q;

	// ==================================================
	// Mixer
	// ==================================================

	// Channel B carries four times the weight of channel A
	assign mix = {1'b0, audio_b, 2'b00} + {3'b000, audio_a};

	always_ff @(posedge clk_18) begin
		mix_q <= mix;
	end

	// ==================================================
	// Sigma-delta modulator
	// ==================================================

	// Each overflow of the lower bits emits a one, so the density of
	// ones over 2**MIX_W clocks equals the mix value
	always_ff @(posedge clk_18 or negedge rst_n) begin
		if (!rst_n) begin
			acc_q <= '0;
		end else begin
			acc_q <= {1'b0, acc_q[MIX_W-1:0]} + {1'b0, mix_q};
		end
	end

	assign audio_l = acc_q[MIX_W];

endmodule

/* design/video_blank.sv */
//==================================================
// Video blanking and scanlines
// Blanks the core colour, widens it to the output
// depth by bit repetition and dims odd lines for the
// CRT effects, with sync kept aligned
//==================================================
`timescale 1ns/1ps

module video_blank #(
	parameter int COLOR_IN_W = 3
) (
	input  logic                            clk_18,
	input  logic                            rst_n,
	input  logic [COLOR_IN_W-1:0]           r,
	input  logic [COLOR_IN_W-1:0]           g,
	input  logic [COLOR_IN_W-1:0]           b,
	input  logic                            hs,
	input  logic                            vs,
	input  logic                            hblank,
	input  logic                            vblank,
	cfg_if.sink                             cfg,
	output logic [orbitron_pkg::VGA_W-1:0] vga_r,
	output logic [orbitron_pkg::VGA_W-1:0] vga_g,
	output logic [orbitron_pkg::VGA_W-1:0] vga_b,
	output logic                            vga_hs,
	output logic                            vga_vs
);
	import orbitron_pkg::*;

	logic line_odd_q;
	logic line_odd;
	logic blank;

	// Repeat the input bits MSB first until the output depth is filled
	function automatic logic [VGA_W-1:0] widen(input logic [COLOR_IN_W-1:0] c);
		logic [VGA_W-1:0] w;
		for (int k = 0; k < VGA_W; k++) begin
			w[VGA_W-1-k] = c[COLOR_IN_W-1-(k % COLOR_IN_W)];
		end
		return w;
	endfunction

	function automatic logic [VGA_W-1:0] dim(
		input logic [VGA_W-1:0] v,
		input fx_mode_t         mode,
		input logic             odd
	);
		logic [VGA_W-1:0] res;
		res = v;
		if (odd) begin
			case (mode)
				FX_CRT25: res = v - (v >> 2);
				FX_CRT50: res = v >> 1;
				default:  res = v;
			endcase
		end
		return res;
	endfunction

	// vga_hs still holds the previous hs, so a fall starts the new line now
	assign line_odd = line_odd_q ^ (vga_hs & ~hs);
	assign blank    = hblank | vblank;

	always_ff @(posedge clk_18 or negedge rst_n) begin
		if (!rst_n) begin
			line_odd_q <= 1'b0;
			vga_r      <= '0;
			vga_g      <= '0;
			vga_b      <= '0;
			vga_hs     <= 1'b0;
			vga_vs     <= 1'b0;
		end else begin
			line_odd_q <= line_odd;
			vga_r      <= blank ? '0 : dim(widen(r), cfg.fx_mode, line_odd);
			vga_g      <= blank ? '0 : dim(widen(g), cfg.fx_mode, line_odd);
			vga_b      <= blank ? '0 : dim(widen(b), cfg.fx_mode, line_odd);
			vga_hs     <= hs;
			vga_vs     <= vs;
		end
	end

endmodule

/* design/orbitron_glue.sv */
//==================================================
// Orbitron board glue top level
// Option receiver, player controls, sound DAC and
// video blanking around the Galaxian-class core,
// all in the 18 MHz system clock domain
//==================================================
`timescale 1ns/1ps

module orbitron_glue #(
	parameter int COLOR_IN_W = 3
) (
	input  logic                              clk_18,
	input  logic                              rst_n,

	// Host option link
	input  logic                              spi_sck,
	input  logic                              spi_ss,
	input  logic                              spi_di,
	input  logic [1:0]                        buttons,

	// Player inputs
	input  logic [orbitron_pkg::KBJOY_W-1:0] kbjoy,
	input  logic [orbitron_pkg::JOY_W-1:0]   joystick_0,
	input  logic [orbitron_pkg::JOY_W-1:0]   joystick_1,

	// Core sound and video
	input  logic [orbitron_pkg::SND_W-1:0]   audio_a,
	input  logic [orbitron_pkg::SND_W-1:0]   audio_b,
	input  logic [COLOR_IN_W-1:0]             core_r,
	input  logic [COLOR_IN_W-1:0]             core_g,
	input  logic [COLOR_IN_W-1:0]             core_b,
	input  logic                              core_hs,
	input  logic                              core_vs,
	input  logic                              hblank,
	input  logic                              vblank,

	// To the core
	output logic [7:0]                        p1_csjudlr,
	output logic [7:0]                        p2_csjudlr,
	output logic                              core_reset,

	// Board outputs
	output logic                              audio_l,
	output logic                              audio_r,
	output logic [orbitron_pkg::VGA_W-1:0]   vga_r,
	output logic [orbitron_pkg::VGA_W-1:0]   vga_g,
	output logic [orbitron_pkg::VGA_W-1:0]   vga_b,
	output logic                              vga_hs,
	output logic                              vga_vs
);

	cfg_if cfg_bus ();

	option_rx u_option_rx (
		.clk_18  (clk_18),
		.rst_n   (rst_n),
		.spi_sck (spi_sck),
		.spi_ss  (spi_ss),
		.spi_di  (spi_di),
		.cfg     (cfg_bus.source)
	);

	// The host menu reset and the board button both restart the core
	assign core_reset = cfg_bus.reset_req | buttons[1];

	player_controls u_player_controls (
		.clk_18     (clk_18),
		.rst_n      (rst_n),
		.kbjoy      (kbjoy),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.cfg        (cfg_bus.sink),
		.p1_csjudlr (p1_csjudlr),
		.p2_csjudlr (p2_csjudlr)
	);

	// Mono sound, the same stream goes to both pins
	sound_dac u_sound_dac (
		.clk_18  (clk_18),
		.rst_n   (rst_n),
		.audio_a (audio_a),
		.audio_b (audio_b),
		.audio_l (audio_l)
	);

	assign audio_r = audio_l;

	video_blank #(
		.COLOR_IN_W (COLOR_IN_W)
	) u_video_blank (
		.clk_18 (clk_18),
		.rst_n  (rst_n),
		.r      (core_r),
		.g      (core_g),
		.b      (core_b),
		.hs     (core_hs),
		.vs     (core_vs),
		.hblank (hblank),
		.vblank (vblank),
		.cfg    (cfg_bus.sink),
		.vga_r  (vga_r),
		.vga_g  (vga_g),
		.vga_b  (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs)
	);

endmodule

/* testbench/orbitron_glue_properties.sv */
//==================================================
// Orbitron glue assertions
// Reference models of the option link, the player
// controls and the video path, checked against the
// glue outputs by concurrent assertions
//==================================================
`timescale 1ns/1ps

module orbitron_glue_properties #(
	parameter int COLOR_IN_W = 3
) (
	input logic                              clk_18,
	input logic                              rst_n,
	input logic                              spi_sck,
	input logic                              spi_ss,
	input logic                              spi_di,
	input logic [1:0]                        buttons,
	input logic [orbitron_pkg::KBJOY_W-1:0] kbjoy,
	input logic [orbitron_pkg::JOY_W-1:0]   joystick_0,
	input logic [orbitron_pkg::JOY_W-1:0]   joystick_1,
	input logic [COLOR_IN_W-1:0]             core_r,
	input logic [COLOR_IN_W-1:0]             core_g,
	input logic [COLOR_IN_W-1:0]             core_b,
	input logic                              core_hs,
	input logic                              core_vs,
	input logic                              hblank,
	input logic                              vblank,
	input logic                              cfg_update,
	input logic [7:0]                        p1_csjudlr,
	input logic [7:0]                        p2_csjudlr,
	input logic                              core_reset,
	input logic                              audio_l,
	input logic                              audio_r,
	input logic [orbitron_pkg::VGA_W-1:0]   vga_r,
	input logic [orbitron_pkg::VGA_W-1:0]   vga_g,
	input logic [orbitron_pkg::VGA_W-1:0]   vga_b,
	input logic                              vga_hs,
	input logic                              vga_vs
);
	import orbitron_pkg::*;

	// Read by the testbench for its closing report
	int unsigned fail_count = 0;

	logic               sck_q;
	logic               ss_q;
	logic [3:0]         bits_q;
	opt_byte_t          shift_q;
	opt_byte_t          exp_opt;
	logic [2:0]         pending_q;
	logic               got_update_q;
	logic               good_end;
	logic               settle;
	logic               exp_reset;
	logic [3:0]         dirs;
	logic [3:0]         turned;
	logic               fire;
	logic               hs_q;
	logic               vs_q;
	logic               odd_q;
	logic               odd_now;
	logic [7:0]         exp_p1_q;
	logic [7:0]         exp_p2_q;
	logic [3*VGA_W-1:0] exp_rgb_q;
	logic [3*VGA_W-1:0] vga_rgb;

	function automatic logic [VGA_W-1:0] expand(input logic [COLOR_IN_W-1:0] c);
		logic [COLOR_IN_W*VGA_W-1:0] rep;
		rep = {VGA_W{c}};
		return rep[COLOR_IN_W*VGA_W-1 -: VGA_W];
	endfunction

	function automatic logic [VGA_W-1:0] shade(
		input logic [VGA_W-1:0] v,
		input logic             odd,
		input logic [1:0]       fx
	);
		logic [VGA_W-1:0] quarter;
		quarter = v / 6'd4;
		if (odd && fx == FX_CRT25) return v - quarter;
		if (odd && fx == FX_CRT50) return v / 6'd2;
		return v;
	endfunction

	// ==================================================
	// Option link shadow
	// ==================================================

	assign good_end = spi_ss & ~ss_q & (bits_q == 4'd8);
	// The DUT needs a few clocks to pass a new byte through its synchronisers
	assign settle   = (pending_q == 3'd0);

	always_ff @(posedge clk_18 or negedge rst_n) begin
		if (!rst_n) begin
			sck_q        <= 1'b0;
			ss_q         <= 1'b1;
			bits_q       <= '0;
			shift_q      <= '0;
			exp_opt      <= '0;
			pending_q    <= '0;
			got_update_q <= 1'b0;
		end else begin
			sck_q <= spi_sck;
			ss_q  <= spi_ss;
			if (spi_ss) begin
				bits_q <= '0;
			end else if (spi_sck && !sck_q) begin
				shift_q <= {shift_q[6:0], spi_di};
				if (bits_q != 4'd15) bits_q <= bits_q + 1'b1;
			end
			if (good_end) begin
				exp_opt      <= shift_q;
				pending_q    <= 3'd6;
				got_update_q <= 1'b0;
			end else if (pending_q != 3'd0) begin
				pending_q <= pending_q - 1'b1;
				if (cfg_update) got_update_q <= 1'b1;
			end
		end
	end

	// ==================================================
	// Controls and video reference
	// ==================================================

	assign exp_reset = exp_opt[OPT_RESET] | exp_opt[OPT_RESET_T] | buttons[1];

	// Upright order is up, down, left, right
	assign dirs = {kbjoy[7] | joystick_0[0] | joystick_1[0],
		kbjoy[6] | joystick_0[1] | joystick_1[1],
		kbjoy[4] | joystick_0[3] | joystick_1[3],
		kbjoy[5] | joystick_0[2] | joystick_1[2]};
	assign turned  = exp_opt[OPT_ROTATE] ? dirs : {dirs[1], dirs[0], dirs[2], dirs[3]};
	assign fire    = kbjoy[0] | joystick_0[4] | joystick_1[4];
	assign odd_now = odd_q ^ (hs_q & ~core_hs);
	assign vga_rgb = {vga_r, vga_g, vga_b};

	always_ff @(posedge clk_18 or negedge rst_n) begin
		if (!rst_n) begin
			hs_q      <= 1'b0;
			vs_q      <= 1'b0;
			odd_q     <= 1'b0;
			exp_p1_q  <= '0;
			exp_p2_q  <= '0;
			exp_rgb_q <= '0;
		end else begin
			hs_q     <= core_hs;
			vs_q     <= core_vs;
			odd_q    <= odd_now;
			exp_p1_q <= {1'b0, kbjoy[3], kbjoy[1], fire, 2'b00, turned[0], turned[1]};
			exp_p2_q <= {2'b00, kbjoy[2], fire, 2'b00, turned[3], turned[2]};
			if (hblank || vblank) begin
				exp_rgb_q <= '0;
			end else begin
				exp_rgb_q <= {shade(expand(core_r), odd_now, exp_opt[OPT_FX_LO +: 2]),
					shade(expand(core_g), odd_now, exp_opt[OPT_FX_LO +: 2]),
					shade(expand(core_b), odd_now, exp_opt[OPT_FX_LO +: 2])};
			end
		end
	end

	// ==================================================
	// Assertions
	// ==================================================

	a_update_seen: assert property (@(posedge clk_18) disable iff (!rst_n)
		(pending_q == 3'd2) |-> got_update_q)
	else begin
		fail_count = fail_count + 1;
		$error("No cfg_update within 4 clocks of a complete option frame");
	end

	// Also rules out an update after a frame of the wrong length
	a_update_window: assert property (@(posedge clk_18) disable iff (!rst_n)
		cfg_update |-> (pending_q == 3'd3 || pending_q == 3'd4))
	else begin
		fail_count = fail_count + 1;
		$error("cfg_update pulsed outside 3 to 4 clocks after a complete frame");
	end

	a_core_reset: assert property (@(posedge clk_18) disable iff (!rst_n)
		settle |-> (core_reset == exp_reset))
	else begin
		fail_count = fail_count + 1;
		$error("core_reset expected %b, actual %b",
			$sampled(exp_reset), $sampled(core_reset));
	end

	a_controls: assert property (@(posedge clk_18) disable iff (!rst_n)
		settle |-> (p1_csjudlr == exp_p1_q && p2_csjudlr == exp_p2_q))
	else begin
		fail_count = fail_count + 1;
		$error("Player controls expected p1 %h p2 %h, actual p1 %h p2 %h",
			$sampled(exp_p1_q), $sampled(exp_p2_q),
			$sampled(p1_csjudlr), $sampled(p2_csjudlr));
	end

	a_video: assert property (@(posedge clk_18) disable iff (!rst_n)
		settle |-> (vga_rgb == exp_rgb_q))
	else begin
		fail_count = fail_count + 1;
		$error("VGA colour expected %h, actual %h",
			$sampled(exp_rgb_q), $sampled(vga_rgb));
	end

	a_sync: assert property (@(posedge clk_18) disable iff (!rst_n)
		vga_hs == hs_q && vga_vs == vs_q)
	else begin
		fail_count = fail_count + 1;
		$error("VGA sync expected hs %b vs %b, actual hs %b vs %b",
			$sampled(hs_q), $sampled(vs_q), $sampled(vga_hs), $sampled(vga_vs));
	end

	a_audio_pair: assert property (@(posedge clk_18) audio_r == audio_l)
	else begin
		fail_count = fail_count + 1;
		$error("audio_r expected %b, actual %b", $sampled(audio_l), $sampled(audio_r));
	end

	a_reset_values: assert property (@(posedge clk_18)
		!rst_n |-> (p1_csjudlr == '0 && p2_csjudlr == '0 && !audio_l &&
			vga_r == '0 && vga_g == '0 && vga_b == '0 && !vga_hs && !vga_vs))
	else begin
		fail_count = fail_count + 1;
		$error("Outputs are not zero while reset is held");
	end

endmodule

bind orbitron_glue orbitron_glue_properties #(
	.COLOR_IN_W (COLOR_IN_W)
) props (
	.clk_18     (clk_18),
	.rst_n      (rst_n),
	.spi_sck    (spi_sck),
	.spi_ss     (spi_ss),
	.spi_di     (spi_di),
	.buttons    (buttons),
	.kbjoy      (kbjoy),
	.joystick_0 (joystick_0),
	.joystick_1 (joystick_1),
	.core_r     (core_r),
	.core_g     (core_g),
	.core_b     (core_b),
	.core_hs    (core_hs),
	.core_vs    (core_vs),
	.hblank     (hblank),
	.vblank     (vblank),
	.cfg_update (cfg_bus.cfg_update),
	.p1_csjudlr (p1_csjudlr),
	.p2_csjudlr (p2_csjudlr),
	.core_reset (core_reset),
	.audio_l    (audio_l),
	.audio_r    (audio_r),
	.vga_r      (vga_r),
	.vga_g      (vga_g),
	.vga_b      (vga_b),
	.vga_hs     (vga_hs),
	.vga_vs     (vga_vs)
);

/* testbench/tb_orbitron_glue.sv */
//==================================================
// Orbitron glue testbench
// Drives the option link, player inputs, sound and
// video into the glue; checks the DAC density and
// collects the bound assertion results
//==================================================
`timescale 1ns/1ps

module tb_orbitron_glue;
	import orbitron_pkg::*;

	localparam int COLOR_IN_W  = 3;
	localparam int CLK_PERIOD  = 100;
	localparam int SCK_PHASE   = 4;
	localparam int SETTLE      = 8;
	localparam int FRAMES      = 8;
	localparam int CTRL_STEPS  = 300;
	localparam int AUDIO_PAIRS = 5;
	localparam int DAC_WINDOW  = 2048;
	localparam int VIDEO_STEPS = 500;
	localparam int LINE_LEN    = 24;

	// Clocks per option frame, then the whole run with a 20 percent margin
	localparam int FRAME_CYCLES = (2 * 8 + 2) * SCK_PHASE + SETTLE;
	localparam int RUN_CYCLES   = 8 + FRAMES * FRAME_CYCLES + 2 * CTRL_STEPS
		+ AUDIO_PAIRS * (DAC_WINDOW + 3) + 3 * VIDEO_STEPS;
	localparam longint TIMEOUT_NS = longint'(RUN_CYCLES) * CLK_PERIOD * 12 / 10;

	logic                  clk_18;
	logic                  rst_n;
	logic                  spi_sck;
	logic                  spi_ss;
	logic                  spi_di;
	logic [1:0]            buttons;
	logic [KBJOY_W-1:0]    kbjoy;
	logic [JOY_W-1:0]      joystick_0;
	logic [JOY_W-1:0]      joystick_1;
	logic [SND_W-1:0]      audio_a;
	logic [SND_W-1:0]      audio_b;
	logic [COLOR_IN_W-1:0] core_r;
	logic [COLOR_IN_W-1:0] core_g;
	logic [COLOR_IN_W-1:0] core_b;
	logic                  core_hs;
	logic                  core_vs;
	logic                  hblank;
	logic                  vblank;
	logic [7:0]            p1_csjudlr;
	logic [7:0]            p2_csjudlr;
	logic                  core_reset;
	logic                  audio_l;
	logic                  audio_r;
	logic [VGA_W-1:0]      vga_r;
	logic [VGA_W-1:0]      vga_g;
	logic [VGA_W-1:0]      vga_b;
	logic                  vga_hs;
	logic                  vga_vs;

	int          errors = 0;
	int unsigned assert_errors;

	orbitron_glue #(
		.COLOR_IN_W (COLOR_IN_W)
	) uut (
		.clk_18     (clk_18),
		.rst_n      (rst_n),
		.spi_sck    (spi_sck),
		.spi_ss     (spi_ss),
		.spi_di     (spi_di),
		.buttons    (buttons),
		.kbjoy      (kbjoy),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.audio_a    (audio_a),
		.audio_b    (audio_b),
		.core_r     (core_r),
		.core_g     (core_g),
		.core_b     (core_b),
		.core_hs    (core_hs),
		.core_vs    (core_vs),
		.hblank     (hblank),
		.vblank     (vblank),
		.p1_csjudlr (p1_csjudlr),
		.p2_csjudlr (p2_csjudlr),
		.core_reset (core_reset),
		.audio_l    (audio_l),
		.audio_r    (audio_r),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs)
	);

	always #(CLK_PERIOD / 2) clk_18 = ~clk_18;

	// ==================================================
	// Stimulus tasks
	// ==================================================

	// MSB first, each SCK phase lasts SCK_PHASE clocks
	task automatic send_frame(input opt_byte_t data, input int nbits);
		@(negedge clk_18);
		spi_ss = 1'b0;
		for (int i = 0; i < nbits; i++) begin
			spi_di = data[7-i];
			repeat (SCK_PHASE) @(negedge clk_18);
			spi_sck = 1'b1;
			repeat (SCK_PHASE) @(negedge clk_18);
			spi_sck = 1'b0;
		end
		repeat (SCK_PHASE) @(negedge clk_18);
		spi_ss = 1'b1;
		// The decoded levels move 3 to 4 clocks after slave select rises
		repeat (SETTLE) @(negedge clk_18);
	endtask

	task automatic drive_controls(input int steps);
		logic [31:0] rnd;
		logic [31:0] rnd2;
		for (int i = 0; i < steps; i++) begin
			@(negedge clk_18);
			rnd  = $urandom();
			rnd2 = $urandom();
			// ANDing two draws keeps the inputs sparse so the ORs still toggle
			kbjoy      = rnd[9:0] & rnd[19:10];
			buttons    = rnd[31:30];
			joystick_0 = rnd2[7:0] & rnd2[15:8];
			joystick_1 = rnd2[23:16] & rnd2[31:24];
		end
	endtask

	task automatic check_audio(input int pairs);
		logic [31:0] rnd;
		int          expected;
		int          ones;
		for (int p = 0; p < pairs; p++) begin
			@(negedge clk_18);
			rnd      = $urandom();
			audio_a  = rnd[7:0];
			audio_b  = rnd[15:8];
			expected = 4 * int'(audio_b) + int'(audio_a);
			// One clock for the mix register, one for the accumulator
			repeat (2) @(negedge clk_18);
			ones = 0;
			for (int c = 0; c < DAC_WINDOW; c++) begin
				@(negedge clk_18);
				ones += int'(audio_l);
			end
			if (ones > expected + 1 || ones < expected - 1) begin
				$display("** Error [audio density] a=%0d b=%0d expected %0d, actual %0d",
					audio_a, audio_b, expected, ones);
				errors++;
			end
		end
	endtask

	// Sync is low for the first two clocks of each line
	task automatic drive_video(input int steps);
		logic [31:0] rnd;
		int          pos;
		pos = 0;
		for (int i = 0; i < steps; i++) begin
			@(negedge clk_18);
			rnd     = $urandom();
			core_r  = rnd[COLOR_IN_W-1:0];
			core_g  = rnd[8 +: COLOR_IN_W];
			core_b  = rnd[16 +: COLOR_IN_W];
			core_hs = (pos >= 2);
			hblank  = (pos < 4) || (pos >= LINE_LEN - 2);
			vblank  = (rnd[27:24] == 4'h0);
			core_vs = (rnd[31:28] != 4'h0);
			pos     = (pos + 1) % LINE_LEN;
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		void'($urandom(70));
		clk_18     = 1'b0;
		rst_n      = 1'b1;
		spi_sck    = 1'b0;
		spi_ss     = 1'b1;
		spi_di     = 1'b0;
		buttons    = '0;
		kbjoy      = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		audio_a    = '0;
		audio_b    = '0;
		core_r     = '0;
		core_g     = '0;
		core_b     = '0;
		core_hs    = 1'b0;
		core_vs    = 1'b0;
		hblank     = 1'b0;
		vblank     = 1'b0;
		// A real falling edge starts the asynchronous reset
		#1 rst_n = 1'b0;
		repeat (3) @(posedge clk_18);
		@(negedge clk_18);
		rst_n = 1'b1;

		// Both reset bits, then a 7-bit frame that must change nothing
		send_frame(8'h01, 8);
		send_frame(8'h41, 8);
		send_frame(8'h40, 8);
		send_frame(8'hff, 7);

		// Upright mapping, then the quarter-turned one
		send_frame(8'h04, 8);
		drive_controls(CTRL_STEPS);
		send_frame(8'h00, 8);
		drive_controls(CTRL_STEPS);

		check_audio(AUDIO_PAIRS);

		// No effect, then CRT 25 and CRT 50 scanlines
		drive_video(VIDEO_STEPS);
		send_frame(8'h10, 8);
		drive_video(VIDEO_STEPS);
		send_frame(8'h18, 8);
		drive_video(VIDEO_STEPS);
		repeat (2) @(negedge clk_18);

		assert_errors = uut.props.fail_count;
		$display("Summary: %0d testbench errors, %0d assertion failures",
			errors, assert_errors);
		if (errors == 0 && assert_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Test failed");
		$finish;
	end

endmodule

/* sources.f */
design/orbitron_pkg.sv
design/cfg_if.sv
design/option_rx.sv
design/player_controls.sv
design/sound_dac.sv
design/video_blank.sv
design/orbitron_glue.sv
testbench/orbitron_glue_properties.sv
testbench/tb_orbitron_glue.sv

/* Makefile */
# Verilator build, run, lint and clean for the Orbitron board glue

VERILATOR  ?= verilator
TOP        ?= tb_orbitron_glue
RTL_TOP    ?= orbitron_glue
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= Test completed successfully

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter design/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass message appears as a line of its own
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
